// File: hdl/mcPkg.sv
// Single-rank DDR4 scheduler constants; all timings are in controller clocks, one command per clock
package mcPkg;

   // --------------------
   // Geometry
   // --------------------
   localparam int BANKS       = 4;
   localparam int BANK_BITS   = 2;
   localparam int ROW_BITS    = 14;
   localparam int COL_BITS    = 10;
   localparam int QUEUE_DEPTH = 4;

   // --------------------
   // Timing in clocks
   // --------------------
   // ACT to CAS, same bank
   localparam int T_RCD = 4;
   // ACT to PRE, same bank
   localparam int T_RAS = 10;
   // PRE to ACT, and PREA to REF
   localparam int T_RP = 4;
   // REF to any command
   localparam int T_RFC = 20;
   // Refresh interval
   localparam int T_REFI = 400;
   // Holds T_REFI - 1, the largest value loaded into any timer
   localparam int TIMER_BITS = 9;

   typedef logic [BANK_BITS-1:0] bankT;
   typedef logic [ROW_BITS-1:0]  rowT;
   typedef logic [COL_BITS-1:0]  colT;

   typedef enum logic [2:0] {
      NOP,
      ACT,
      RD,
      WR,
      PRE,
      PREA,
      REF
   } memCmdT;

   // One queued transaction
   typedef struct packed {
      logic write;
      bankT bank;
      rowT  row;
      colT  col;
   } mcTxnT;

endpackage

// File: hdl/mcTxnQueue.sv
// In-order request FIFO; nothing is accepted before calDone, and a full queue holds accept low
`timescale 1ns/1ns

module mcTxnQueue (
   input  logic          clk,
   input  logic          rst_r1,
   input  logic          calDone,
   input  logic          reqValid,
   input  logic          reqWrite,
   input  mcPkg::bankT   reqBank,
   input  mcPkg::rowT    reqRow,
   input  mcPkg::colT    reqCol,
   input  logic          pop,
   output logic          accept,
   output logic          headValid,
   output mcPkg::mcTxnT  headTxn
);

   mcPkg::mcTxnT                          entries [mcPkg::QUEUE_DEPTH];
   logic [$clog2(mcPkg::QUEUE_DEPTH)-1:0]   wrPtr;
   logic [$clog2(mcPkg::QUEUE_DEPTH)-1:0]   rdPtr;
   logic [$clog2(mcPkg::QUEUE_DEPTH+1)-1:0] count;
   logic                                  push;

   assign accept    = calDone && (count != mcPkg::QUEUE_DEPTH);
   assign push      = reqValid && accept;
   assign headValid = (count != '0);
   assign headTxn   = entries[rdPtr];

   // Entry storage
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wrPtr] <= '{write: reqWrite, bank: reqBank, row: reqRow, col: reqCol};
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!rst_r1) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wrPtr <= (wrPtr == mcPkg::QUEUE_DEPTH - 1) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == mcPkg::QUEUE_DEPTH - 1) ? '0 : rdPtr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// File: hdl/mcPageTable.sv
// Open-row table for a single rank; a row opened by ACT stays open until PRE or PREA
`timescale 1ns/1ns

module mcPageTable (
   input  logic           clk,
   input  logic           rst_r1,
   input  mcPkg::memCmdT  issueCmd,
   input  mcPkg::bankT    issueBank,
   input  mcPkg::rowT     issueRow,
   input  mcPkg::mcTxnT   headTxn,
   output logic           headOpen,
   output logic           headHit,
   output logic           anyOpen
);

   logic [mcPkg::BANKS-1:0] openFlag;
   mcPkg::rowT              openRow [mcPkg::BANKS];

   // Open flags per bank
   always_ff @(posedge clk) begin
      if (!rst_r1) begin
         openFlag <= '0;
      end else if (issueCmd == mcPkg::PREA) begin
         openFlag <= '0;
      end else if (issueCmd == mcPkg::ACT) begin
         openFlag[issueBank] <= 1'b1;
      end else if (issueCmd == mcPkg::PRE) begin
         openFlag[issueBank] <= 1'b0;
      end
   end

   // Row held by each bank, meaningful only while its flag is set
   always_ff @(posedge clk) begin
      if (issueCmd == mcPkg::ACT) begin
         openRow[issueBank] <= issueRow;
      end
   end

   assign headOpen = openFlag[headTxn.bank];
   assign headHit  = headOpen && (openRow[headTxn.bank] == headTxn.row);
   assign anyOpen  = |openFlag;

endmodule

// File: hdl/mcTimingCounters.sv
// Per-bank tRCD/tRAS/tRP timers plus tRFC and tREFI; refresh interval runs only while calDone
`timescale 1ns/1ns

module mcTimingCounters (
   input  logic           clk,
   input  logic           rst_r1,
   input  logic           calDone,
   input  mcPkg::memCmdT  issueCmd,
   input  mcPkg::bankT    issueBank,
   input  mcPkg::mcTxnT   headTxn,
   output logic           actOk,
   output logic           casOk,
   output logic           preOk,
   output logic           allPreOk,
   output logic           refDue,
   output logic           busy
);

   typedef logic [mcPkg::TIMER_BITS-1:0] timerT;

   timerT actTimer [mcPkg::BANKS];
   timerT casTimer [mcPkg::BANKS];
   timerT preTimer [mcPkg::BANKS];
   timerT busyCnt;
   timerT refCnt;
   logic  anyRpRunning;

   function automatic timerT tick(timerT t);
      return (t == '0) ? t : t - 1'b1;
   endfunction

   // --------------------
   // Bank timers
   // --------------------
   // Loaded with N-1 so the next command may go N clocks after this one
   always_ff @(posedge clk) begin
      if (!rst_r1) begin
         for (int b = 0; b < mcPkg::BANKS; b++) begin
            actTimer[b] <= '0;
            casTimer[b] <= '0;
            preTimer[b] <= '0;
         end
         busyCnt <= '0;
      end else begin
         for (int b = 0; b < mcPkg::BANKS; b++) begin
            if (issueCmd == mcPkg::ACT && issueBank == mcPkg::bankT'(b)) begin
               casTimer[b] <= timerT'(mcPkg::T_RCD - 1);
               preTimer[b] <= timerT'(mcPkg::T_RAS - 1);
            end else begin
               casTimer[b] <= tick(casTimer[b]);
               preTimer[b] <= tick(preTimer[b]);
            end
            if (issueCmd == mcPkg::PREA ||
                (issueCmd == mcPkg::PRE && issueBank == mcPkg::bankT'(b))) begin
               actTimer[b] <= timerT'(mcPkg::T_RP - 1);
            end else begin
               actTimer[b] <= tick(actTimer[b]);
            end
         end
         if (issueCmd == mcPkg::REF) begin
            busyCnt <= timerT'(mcPkg::T_RFC - 1);
         end else if (issueCmd == mcPkg::PREA) begin
            busyCnt <= timerT'(mcPkg::T_RP - 1);
         end else begin
            busyCnt <= tick(busyCnt);
         end
      end
   end

   // --------------------
   // Refresh interval
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_r1) begin
         refCnt <= timerT'(mcPkg::T_REFI - 1);
         refDue <= 1'b0;
      end else if (issueCmd == mcPkg::REF) begin
         refCnt <= timerT'(mcPkg::T_REFI - 1);
         refDue <= 1'b0;
      end else if (calDone && !refDue) begin
         if (refCnt == '0) begin
            refDue <= 1'b1;
         end else begin
            refCnt <= refCnt - 1'b1;
         end
      end
   end

   always_comb begin
      allPreOk     = 1'b1;
      anyRpRunning = 1'b0;
      for (int b = 0; b < mcPkg::BANKS; b++) begin
         allPreOk     = allPreOk && (preTimer[b] == '0);
         anyRpRunning = anyRpRunning || (actTimer[b] != '0);
      end
   end

   assign actOk = (actTimer[headTxn.bank] == '0);
   assign casOk = (casTimer[headTxn.bank] == '0);
   assign preOk = (preTimer[headTxn.bank] == '0);
   // A single-bank PRE also has to finish its tRP before REF
   assign busy  = (busyCnt != '0) || anyRpRunning;

endmodule

// File: hdl/mcCmdFsm.sv
// Strictly in-order command picker; at most one command per clock and refresh takes priority
`timescale 1ns/1ns

module mcCmdFsm (
   input  logic           clk,
   input  logic           rst_r1,
   input  logic           headValid,
   input  mcPkg::mcTxnT   headTxn,
   input  logic           headOpen,
   input  logic           headHit,
   input  logic           anyOpen,
   input  logic           actOk,
   input  logic           casOk,
   input  logic           preOk,
   input  logic           allPreOk,
   input  logic           refDue,
   input  logic           busy,
   output logic           pop,
   output mcPkg::memCmdT  issueCmd,
   output mcPkg::bankT    issueBank,
   output mcPkg::rowT     issueRow,
   output mcPkg::colT     issueCol
);

   typedef enum logic [1:0] {
      SERVE,
      REF_PRECHARGE,
      REF_WAIT,
      REF_ISSUE
   } fsmStateT;

   fsmStateT state;
   fsmStateT nextState;

   // Address fields always come from the queue head
   assign issueBank = headTxn.bank;
   assign issueRow  = headTxn.row;
   assign issueCol  = headTxn.col;

   always_ff @(posedge clk) begin
      if (!rst_r1) begin
         state <= SERVE;
      end else begin
         state <= nextState;
      end
   end

   // --------------------
   // Command decision
   // --------------------
   always_comb begin
      nextState = state;
      issueCmd  = mcPkg::NOP;
      pop       = 1'b0;
      case (state)
         SERVE: begin
            if (refDue) begin
               // Nothing new goes out once a refresh is pending
               nextState = REF_PRECHARGE;
            end else if (headValid) begin
               if (headHit) begin
                  if (casOk) begin
                     issueCmd = headTxn.write ? mcPkg::WR : mcPkg::RD;
                     pop      = 1'b1;
                  end
               end else if (headOpen) begin
                  // Row conflict, close the bank first
                  if (preOk) begin
                     issueCmd = mcPkg::PRE;
                  end
               end else if (actOk) begin
                  issueCmd = mcPkg::ACT;
               end
            end
         end
         REF_PRECHARGE: begin
            if (!anyOpen) begin
               nextState = REF_WAIT;
            end else if (allPreOk) begin
               issueCmd  = mcPkg::PREA;
               nextState = REF_WAIT;
            end
         end
         REF_WAIT: begin
            // tRP after the precharge
            if (!busy) begin
               issueCmd  = mcPkg::REF;
               nextState = REF_ISSUE;
            end
         end
         REF_ISSUE: begin
            // REF is out, hold off until tRFC expires
            if (!busy) begin
               nextState = SERVE;
            end
         end
         default: begin
            nextState = SERVE;
         end
      endcase
   end

endmodule

// File: hdl/mcCmdEncode.sv
// DDR4 command pin register with one clock of latency; rows are 14 bits so ACT drives A16..A14 low
`timescale 1ns/1ns

module mcCmdEncode (
   input  logic           clk,
   input  logic           rst_r1,
   input  mcPkg::memCmdT  issueCmd,
   input  mcPkg::bankT    issueBank,
   input  mcPkg::rowT     issueRow,
   input  mcPkg::colT     issueCol,
   output logic           memCsN,
   output logic           memActN,
   output logic           memRasN,
   output logic           memCasN,
   output logic           memWeN,
   output mcPkg::bankT    memBa,
   output mcPkg::rowT     memAdr,
   output logic           rdCas,
   output logic           wrCas,
   output logic           refAck
);

   // --------------------
   // Control pins and status pulses
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_r1) begin
         memCsN  <= 1'b1;
         memActN <= 1'b1;
         {memRasN, memCasN, memWeN} <= 3'b111;
         rdCas   <= 1'b0;
         wrCas   <= 1'b0;
         refAck  <= 1'b0;
      end else begin
         memCsN  <= (issueCmd == mcPkg::NOP);
         memActN <= (issueCmd != mcPkg::ACT);
         rdCas   <= (issueCmd == mcPkg::RD);
         wrCas   <= (issueCmd == mcPkg::WR);
         refAck  <= (issueCmd == mcPkg::REF);
         case (issueCmd)
            // RAS/CAS/WE carry upper row bits during ACT
            mcPkg::ACT:             {memRasN, memCasN, memWeN} <= 3'b000;
            mcPkg::RD:              {memRasN, memCasN, memWeN} <= 3'b101;
            mcPkg::WR:              {memRasN, memCasN, memWeN} <= 3'b100;
            mcPkg::PRE, mcPkg::PREA: {memRasN, memCasN, memWeN} <= 3'b010;
            mcPkg::REF:             {memRasN, memCasN, memWeN} <= 3'b001;
            default:                {memRasN, memCasN, memWeN} <= 3'b111;
         endcase
      end
   end

   // Address and bank
   always_ff @(posedge clk) begin
      memBa <= issueBank;
      case (issueCmd)
         mcPkg::ACT:            memAdr <= issueRow;
         mcPkg::RD, mcPkg::WR:  memAdr <= mcPkg::rowT'(issueCol);
         // A10 high selects all banks
         mcPkg::PREA:           memAdr <= mcPkg::rowT'(1 << 10);
         default:               memAdr <= '0;
      endcase
   end

endmodule

// File: hdl/mcTop.sv
// Single-rank four-bank DDR4 command scheduler; in-order service, no data path, no self-refresh
`timescale 1ns/1ns

module mcTop (
   input  logic         clk,
   input  logic         rst_r1,
   input  logic         calDone,
   input  logic         reqValid,
   input  logic         reqWrite,
   input  mcPkg::bankT  reqBank,
   input  mcPkg::rowT   reqRow,
   input  mcPkg::colT   reqCol,
   output logic         accept,
   output logic         memCsN,
   output logic         memActN,
   output logic         memRasN,
   output logic         memCasN,
   output logic         memWeN,
   output mcPkg::bankT  memBa,
   output mcPkg::rowT   memAdr,
   output logic         rdCas,
   output logic         wrCas,
   output logic         refAck
);

   mcPkg::mcTxnT  headTxn;
   logic          headValid;
   logic          pop;
   logic          headOpen;
   logic          headHit;
   logic          anyOpen;
   logic          actOk;
   logic          casOk;
   logic          preOk;
   logic          allPreOk;
   logic          refDue;
   logic          busy;
   mcPkg::memCmdT issueCmd;
   mcPkg::bankT   issueBank;
   mcPkg::rowT    issueRow;
   mcPkg::colT    issueCol;

   mcTxnQueue uQueue (
      .clk       (clk),
      .rst_r1    (rst_r1),
      .calDone   (calDone),
      .reqValid  (reqValid),
      .reqWrite  (reqWrite),
      .reqBank   (reqBank),
      .reqRow    (reqRow),
      .reqCol    (reqCol),
      .pop       (pop),
      .accept    (accept),
      .headValid (headValid),
      .headTxn   (headTxn)
   );

   mcPageTable uPageTable (
      .clk       (clk),
      .rst_r1    (rst_r1),
      .issueCmd  (issueCmd),
      .issueBank (issueBank),
      .issueRow  (issueRow),
      .headTxn   (headTxn),
      .headOpen  (headOpen),
      .headHit   (headHit),
      .anyOpen   (anyOpen)
   );

   mcTimingCounters uTimers (
      .clk       (clk),
      .rst_r1    (rst_r1),
      .calDone   (calDone),
      .issueCmd  (issueCmd),
      .issueBank (issueBank),
      .headTxn   (headTxn),
      .actOk     (actOk),
      .casOk     (casOk),
      .preOk     (preOk),
      .allPreOk  (allPreOk),
      .refDue    (refDue),
      .busy      (busy)
   );

   mcCmdFsm uFsm (
      .clk       (clk),
      .rst_r1    (rst_r1),
      .headValid (headValid),
      .headTxn   (headTxn),
      .headOpen  (headOpen),
      .headHit   (headHit),
      .anyOpen   (anyOpen),
      .actOk     (actOk),
      .casOk     (casOk),
      .preOk     (preOk),
      .allPreOk  (allPreOk),
      .refDue    (refDue),
      .busy      (busy),
      .pop       (pop),
      .issueCmd  (issueCmd),
      .issueBank (issueBank),
      .issueRow  (issueRow),
      .issueCol  (issueCol)
   );

   mcCmdEncode uEncode (
      .clk       (clk),
      .rst_r1    (rst_r1),
      .issueCmd  (issueCmd),
      .issueBank (issueBank),
      .issueRow  (issueRow),
      .issueCol  (issueCol),
      .memCsN    (memCsN),
      .memActN   (memActN),
      .memRasN   (memRasN),
      .memCasN   (memCasN),
      .memWeN    (memWeN),
      .memBa     (memBa),
      .memAdr    (memAdr),
      .rdCas     (rdCas),
      .wrCas     (wrCas),
      .refAck    (refAck)
   );

endmodule

// File: sim/mcTopTb.sv
// Self-checking testbench for mcTop; assumes one rank, in-order service, and a REF within the run
`timescale 1ns/1ns

module mcTopTb;

   localparam int TABLE_LEN = 24;
   localparam int MAX_GAP   = 7;
   localparam int EXP_REFS  = 1;
   // Worst entry is a row conflict plus the longest idle gap
   localparam int TIMEOUT   = TABLE_LEN * (mcPkg::T_RAS + mcPkg::T_RP + mcPkg::T_RCD + MAX_GAP + 4)
                              + EXP_REFS * mcPkg::T_RFC;
   localparam int REF_BOUND = mcPkg::T_REFI + mcPkg::T_RAS + mcPkg::T_RP + mcPkg::T_RFC;

   logic        clk = 1'b0;
   logic        rst_r1;
   logic        calDone;
   logic        reqValid;
   logic        reqWrite;
   mcPkg::bankT reqBank;
   mcPkg::rowT  reqRow;
   mcPkg::colT  reqCol;
   logic        accept;
   logic        memCsN;
   logic        memActN;
   logic        memRasN;
   logic        memCasN;
   logic        memWeN;
   mcPkg::bankT memBa;
   mcPkg::rowT  memAdr;
   logic        rdCas;
   logic        wrCas;
   logic        refAck;

   // Columns are write, bank, row, col
   mcPkg::mcTxnT txnTable [TABLE_LEN] = '{
      '{1'b0, 2'd0, 14'h0010, 10'h000},
      '{1'b1, 2'd0, 14'h0010, 10'h008},
      '{1'b0, 2'd0, 14'h0010, 10'h010},
      '{1'b0, 2'd1, 14'h0020, 10'h020},
      '{1'b1, 2'd1, 14'h0020, 10'h028},
      '{1'b0, 2'd0, 14'h0011, 10'h030},
      '{1'b1, 2'd0, 14'h0011, 10'h038},
      '{1'b0, 2'd2, 14'h0100, 10'h040},
      '{1'b0, 2'd3, 14'h0200, 10'h048},
      '{1'b1, 2'd2, 14'h0101, 10'h050},
      '{1'b0, 2'd3, 14'h0200, 10'h058},
      '{1'b1, 2'd1, 14'h0021, 10'h060},
      '{1'b0, 2'd0, 14'h0012, 10'h068},
      '{1'b1, 2'd0, 14'h0013, 10'h070},
      '{1'b0, 2'd0, 14'h0013, 10'h078},
      '{1'b1, 2'd1, 14'h0022, 10'h080},
      '{1'b0, 2'd2, 14'h0101, 10'h088},
      '{1'b1, 2'd3, 14'h0201, 10'h090},
      '{1'b0, 2'd3, 14'h0202, 10'h098},
      '{1'b1, 2'd0, 14'h0013, 10'h0A0},
      '{1'b0, 2'd1, 14'h3FFF, 10'h3FF},
      '{1'b1, 2'd2, 14'h0102, 10'h1F0},
      '{1'b0, 2'd2, 14'h0102, 10'h1F8},
      '{1'b1, 2'd0, 14'h0014, 10'h200}
   };

   // Checker model of the DRAM state
   logic        openM    [mcPkg::BANKS];
   mcPkg::rowT  openRowM [mcPkg::BANKS];
   int          lastAct  [mcPkg::BANKS];
   int          lastPre  [mcPkg::BANKS];
   int          lastRef;
   int          refStart;
   int          cyc;
   int          casSeen;
   int          accepted;
   int          refSeen;
   logic        sawFull;
   logic        calSeen;
   logic [31:0] rng;

   mcTop uut (.*);

   initial begin
      forever #20 clk = ~clk;
   end

   // --------------------
   // Checks
   // --------------------
   task automatic stopOnError(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic cmdCheck(input mcPkg::memCmdT got, input mcPkg::memCmdT exp, input string what);
      if (got !== exp) begin
         stopOnError($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
      end
   endtask

   task automatic bankCheck(input mcPkg::bankT got, input mcPkg::bankT exp, input string what);
      if (got !== exp) begin
         stopOnError($sformatf("%s is %0d, expected %0d", what, got, exp));
      end
   endtask

   task automatic rowCheck(input mcPkg::rowT got, input mcPkg::rowT exp, input string what);
      if (got !== exp) begin
         stopOnError($sformatf("%s is 0x%h, expected 0x%h", what, got, exp));
      end
   endtask

   task automatic colCheck(input mcPkg::colT got, input mcPkg::colT exp, input string what);
      if (got !== exp) begin
         stopOnError($sformatf("%s is 0x%h, expected 0x%h", what, got, exp));
      end
   endtask

   task automatic pulseCheck(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stopOnError($sformatf("%s is %b, expected %b", what, got, exp));
      end
   endtask

   task automatic gapCheck(input int gap, input int minGap, input string what);
      if (gap < minGap) begin
         stopOnError($sformatf("%s after %0d cycles, minimum is %0d", what, gap, minGap));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // DDR4 truth table back to a command
   task automatic decodePins(output mcPkg::memCmdT cmd);
      if (memCsN) begin
         cmd = mcPkg::NOP;
      end else if (!memActN) begin
         cmd = mcPkg::ACT;
      end else begin
         case ({memRasN, memCasN, memWeN})
            3'b101:  cmd = mcPkg::RD;
            3'b100:  cmd = mcPkg::WR;
            3'b010:  cmd = memAdr[10] ? mcPkg::PREA : mcPkg::PRE;
            3'b001:  cmd = mcPkg::REF;
            default: begin
               cmd = mcPkg::NOP;
               stopOnError("unknown command on the pins");
            end
         endcase
      end
   endtask

   // --------------------
   // Pin monitor
   // --------------------
   // Pins settle at the rising edge, so they are read at the falling one
   always @(negedge clk) begin : pinMonitor
      mcPkg::memCmdT cmd;
      mcPkg::mcTxnT  head;
      int            outstanding;
      cyc++;
      if (cyc > TIMEOUT) begin
         $display("Timeout: transactions or refresh not finished within %0d cycles", TIMEOUT);
         $display("Some tests failed");
         $fatal(1, "Timeout");
      end
      decodePins(cmd);
      head = txnTable[(casSeen < TABLE_LEN) ? casSeen : TABLE_LEN - 1];
      if (!calDone) begin
         pulseCheck(memCsN, 1'b1, "memCsN before calDone");
         pulseCheck(accept, 1'b0, "accept before calDone");
      end else if (!calSeen) begin
         calSeen  = 1'b1;
         refStart = cyc;
      end
      pulseCheck(rdCas, cmd == mcPkg::RD, "rdCas");
      pulseCheck(wrCas, cmd == mcPkg::WR, "wrCas");
      pulseCheck(refAck, cmd == mcPkg::REF, "refAck");
      if (cmd != mcPkg::NOP) begin
         gapCheck(cyc - lastRef, mcPkg::T_RFC, "command after REF");
         if (cmd != mcPkg::REF && cmd != mcPkg::PREA && casSeen >= TABLE_LEN) begin
            stopOnError("bank command with no pending transaction");
         end
      end
      case (cmd)
         mcPkg::ACT: begin
            bankCheck(memBa, head.bank, "ACT bank");
            rowCheck(memAdr, head.row, "ACT row");
            pulseCheck(openM[memBa], 1'b0, "bank open at ACT");
            gapCheck(cyc - lastPre[memBa], mcPkg::T_RP, "ACT after precharge");
            openM[memBa]    = 1'b1;
            openRowM[memBa] = memAdr;
            lastAct[memBa]  = cyc;
         end
         mcPkg::RD, mcPkg::WR: begin
            cmdCheck(cmd, head.write ? mcPkg::WR : mcPkg::RD, "CAS command");
            bankCheck(memBa, head.bank, "CAS bank");
            colCheck(mcPkg::colT'(memAdr), head.col, "CAS column");
            pulseCheck(openM[memBa], 1'b1, "bank open at CAS");
            rowCheck(openRowM[memBa], head.row, "open row at CAS");
            gapCheck(cyc - lastAct[memBa], mcPkg::T_RCD, "CAS after ACT");
            casSeen++;
         end
         mcPkg::PRE: begin
            bankCheck(memBa, head.bank, "PRE bank");
            pulseCheck(openM[memBa], 1'b1, "bank open at PRE");
            if (openRowM[memBa] == head.row) begin
               stopOnError("PRE closes a row that the head still needs");
            end
            gapCheck(cyc - lastAct[memBa], mcPkg::T_RAS, "PRE after ACT");
            openM[memBa]   = 1'b0;
            lastPre[memBa] = cyc;
         end
         mcPkg::PREA: begin
            for (int b = 0; b < mcPkg::BANKS; b++) begin
               if (openM[b]) begin
                  gapCheck(cyc - lastAct[b], mcPkg::T_RAS, "PREA after ACT");
               end
               openM[b]   = 1'b0;
               lastPre[b] = cyc;
            end
         end
         mcPkg::REF: begin
            for (int b = 0; b < mcPkg::BANKS; b++) begin
               pulseCheck(openM[b], 1'b0, "bank open at REF");
               gapCheck(cyc - lastPre[b], mcPkg::T_RP, "REF after precharge");
            end
            refSeen++;
            lastRef  = cyc;
            refStart = cyc;
         end
         default: ;
      endcase
      if (calSeen && (cyc - refStart > REF_BOUND)) begin
         stopOnError("no REF within the refresh bound");
      end
      // Queue occupancy as the model sees it
      outstanding = accepted - casSeen;
      if (calDone) begin
         if (!accept) begin
            sawFull = 1'b1;
         end
         pulseCheck(accept, outstanding < mcPkg::QUEUE_DEPTH, "accept against queue occupancy");
      end
      if (reqValid && accept) begin
         accepted++;
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   initial begin
      logic taken;
      int   gapLen;
      rst_r1   = 1'b0;
      calDone  = 1'b0;
      reqValid = 1'b0;
      reqWrite = 1'b0;
      reqBank  = '0;
      reqRow   = '0;
      reqCol   = '0;
      rng      = 32'd99014;
      cyc      = 0;
      casSeen  = 0;
      accepted = 0;
      refSeen  = 0;
      sawFull  = 1'b0;
      calSeen  = 1'b0;
      refStart = 0;
      lastRef  = -1000;
      for (int b = 0; b < mcPkg::BANKS; b++) begin
         openM[b]    = 1'b0;
         openRowM[b] = '0;
         lastAct[b]  = -1000;
         lastPre[b]  = -1000;
      end
      repeat (4) @(posedge clk);
      #2 rst_r1 = 1'b1;
      repeat (3) @(posedge clk);
      #2 calDone = 1'b1;
      for (int i = 0; i < TABLE_LEN; i++) begin
         // Idle gaps early on, back-to-back burst from entry 12
         if (i % 4 == 3 && i < 12) begin
            reqValid = 1'b0;
            rng      = xorshift32(rng);
            gapLen   = 1 + int'(rng % MAX_GAP);
            repeat (gapLen) @(posedge clk);
            #2;
         end
         reqValid = 1'b1;
         reqWrite = txnTable[i].write;
         reqBank  = txnTable[i].bank;
         reqRow   = txnTable[i].row;
         reqCol   = txnTable[i].col;
         taken    = 1'b0;
         while (!taken) begin
            @(negedge clk);
            taken = accept;
            @(posedge clk);
            #2;
         end
      end
      reqValid = 1'b0;
      while (casSeen < TABLE_LEN || refSeen == 0) @(posedge clk);
      // Window for any stray command
      repeat (mcPkg::T_RFC) @(posedge clk);
      if (!sawFull) begin
         $display("The request burst never filled the queue");
         $display("Some tests failed");
         $fatal(1, "End checks failed");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// File: mcTop.f
hdl/mcPkg.sv
hdl/mcTxnQueue.sv
hdl/mcPageTable.sv
hdl/mcTimingCounters.sv
hdl/mcCmdFsm.sv
hdl/mcCmdEncode.sv
hdl/mcTop.sv
sim/mcTopTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mcTop testbench with Verilator; exit status reflects the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module mcTopTb -f mcTop.f -o mcTopSim \
   && ./obj_dir/mcTopSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
